//--- Makefile
TOP = tb_uart_reg_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
source/bridge_proto_pkg.sv
source/reg_bus_pkg.sv
source/cmd_ctrl.sv
source/rx_field_capture.sv
source/apb_access.sv
source/resp_builder.sv
source/uart_reg_bridge.sv
tb/tb_uart_reg_bridge.sv

//--- source/apb_access.sv
`timescale 1ns/1ps
`default_nettype none

module apb_access (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              apb_start,
  input  logic                              apb_write,
  input  logic [reg_bus_pkg::apb_addr_w-1:0] reg_addr,
  input  reg_bus_pkg::reg_word_u            wdata,
  output logic                              psel,
  output logic                              penable,
  output logic                              pwrite,
  output logic [reg_bus_pkg::apb_addr_w-1:0] paddr,
  output logic [reg_bus_pkg::apb_data_w-1:0] pwdata,
  input  logic [reg_bus_pkg::apb_data_w-1:0] prdata,
  input  logic                              pslverr,
  output reg_bus_pkg::reg_word_u            rdata,
  output logic                              slv_err
);

  // Setup and access phases collapsed into one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
    end else begin
      psel    <= apb_start;
      penable <= apb_start;
      pwrite  <= apb_start & apb_write;
    end
  end

  // Address and write word are already latched upstream
  assign paddr  = reg_addr;
  assign pwdata = wdata.word;

  always_ff @(posedge clk) begin
    if (psel && penable) begin
      rdata.word <= prdata;
      slv_err    <= pslverr; // Held for the response
    end
  end

  // One access per start strobe, never back to back
  a_apb_single: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel ##1 !penable);

endmodule

`default_nettype wire

//--- source/bridge_proto_pkg.sv
`default_nettype none

package bridge_proto_pkg;

  // UART side
  localparam int uart_byte_w = 8;
  localparam int rx_depth    = 8;   // Entries visible in the rx window
  localparam int fifo_lvl_w  = 3;

  localparam logic [fifo_lvl_w-1:0] rx_ready_limit = 3'd7;

  // Command nibble, low half of the first byte
  localparam logic [3:0] cmd_reg_read  = 4'h1;
  localparam logic [3:0] cmd_reg_write = 4'h2;

  // First byte of each response
  localparam logic [uart_byte_w-1:0] resp_write_code = 8'h05;
  localparam logic [uart_byte_w-1:0] resp_error_code = 8'h0F;

  // Response lengths in bytes
  localparam logic [fifo_lvl_w-1:0] resp_len_write = 3'd3;
  localparam logic [fifo_lvl_w-1:0] resp_len_read  = 3'd4;
  localparam logic [fifo_lvl_w-1:0] resp_len_error = 3'd2;

  typedef enum logic [1:0] {
    resp_none,
    resp_write,
    resp_read,
    resp_error
  } resp_kind_t;

endpackage

`default_nettype wire

//--- source/cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   rx_done,
  input  logic [1:0]                             fatal_errors,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0] rx_level,
  input  logic                                   cmd_valid,
  input  logic                                   cmd_is_read,
  input  logic                                   tx_grant,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0] tx_level,
  input  logic                                   tx_wr,
  output logic                                   rx_fifo_flush,
  output logic                                   cap_cmd,
  output logic                                   cap_addr,
  output logic                                   cap_wdata,
  output logic                                   apb_start,
  output logic                                   apb_write,
  output logic                                   resp_active,
  output logic                                   tx_req,
  output bridge_proto_pkg::resp_kind_t           resp_kind,
  output logic [2:0]                             fatal_status
);
  import bridge_proto_pkg::*;
  import reg_bus_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_decode,
    st_addr_wait,
    st_data_wait,
    st_apb,
    st_grant_wait,
    st_respond
  } state_t;

  state_t                 state, next_state;
  resp_kind_t             next_kind;
  logic [1:0]             fatal_r;
  logic [fifo_lvl_w-1:0]  resp_len;
  logic                   field_err;

  assign field_err = (fatal_errors != 2'b00);

  always_comb begin
    next_state = state;
    next_kind  = resp_kind;
    case (state)
      st_idle: begin
        next_kind = resp_none;
        if (rx_done) next_state = st_decode;
      end
      st_decode: next_state = st_addr_wait; // cmd_valid settles here
      st_addr_wait: begin
        if (!cmd_valid || field_err) begin
          next_state = st_grant_wait;
          next_kind  = resp_error;
        end else if (rx_done) begin
          next_state = cmd_is_read ? st_apb : st_data_wait;
          next_kind  = cmd_is_read ? resp_read : resp_write;
        end
      end
      st_data_wait: begin
        if (field_err) begin
          next_state = st_grant_wait;
          next_kind  = resp_error;
        end else if (rx_level == fifo_lvl_w'(word_bytes)) begin
          next_state = st_apb;
        end
      end
      st_apb:        next_state = st_grant_wait;
      st_grant_wait: if (tx_grant) next_state = st_respond;
      st_respond:    if (tx_level == resp_len && !tx_wr) next_state = st_idle;
      default:       next_state = st_idle;
    endcase
  end

  always_comb begin
    case (resp_kind)
      resp_write: resp_len = resp_len_write;
      resp_read:  resp_len = resp_len_read;
      resp_error: resp_len = resp_len_error;
      default:    resp_len = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= st_idle;
      resp_kind     <= resp_none;
      fatal_r       <= 2'b00;
      cap_addr      <= 1'b0;
      cap_wdata     <= 1'b0;
      rx_fifo_flush <= 1'b0;
    end else begin
      state     <= next_state;
      resp_kind <= next_kind;
      // Address and data are taken one cycle after the field completes
      cap_addr  <= (state == st_addr_wait) && (next_state inside {st_apb, st_data_wait});
      cap_wdata <= (state == st_data_wait) && (next_state == st_apb);
      rx_fifo_flush <= cap_cmd | cap_addr | cap_wdata; // Drop the consumed field
      if (state == st_idle)
        fatal_r <= 2'b00;
      else if (state == st_addr_wait || state == st_data_wait)
        fatal_r <= fatal_errors;
    end
  end

  assign cap_cmd      = (state == st_decode);
  assign apb_start    = (state == st_apb);
  assign apb_write    = (resp_kind == resp_write);
  assign resp_active  = (state == st_respond);
  assign tx_req       = (state == st_grant_wait) || (state == st_respond);
  assign fatal_status = {fatal_r, ~cmd_valid}; // Bit 0 flags a bad command

  // The builder may only write while the request is held
  a_wr_in_req: assert property (@(posedge clk) disable iff (!rst_n) tx_wr |-> tx_req);

endmodule

`default_nettype wire

//--- source/reg_bus_pkg.sv
`default_nettype none

package reg_bus_pkg;

  localparam int apb_addr_w = 8;
  localparam int apb_data_w = 32;
  localparam int word_bytes = 4;

  // Register word, seen whole on APB and byte by byte on the UART
  // Byte 3 is the most significant byte
  typedef union packed {
    logic [apb_data_w-1:0]       word;
    logic [word_bytes-1:0][7:0]  bytes;
  } reg_word_u;

endpackage

`default_nettype wire

//--- source/resp_builder.sv
`timescale 1ns/1ps
`default_nettype none

module resp_builder (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    resp_active,
  input  bridge_proto_pkg::resp_kind_t            resp_kind,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0]  tx_level,
  input  logic [reg_bus_pkg::apb_addr_w-1:0]       reg_addr,
  input  reg_bus_pkg::reg_word_u                  rdata,
  input  logic                                    slv_err,
  input  logic [2:0]                              fatal_status,
  output logic                                    tx_wr,
  output logic [bridge_proto_pkg::uart_byte_w-1:0] tx_wdata
);
  import bridge_proto_pkg::*;
  import reg_bus_pkg::*;

  logic                    byte_ok;
  logic [uart_byte_w-1:0]  byte_sel;
  logic [1:0]              rd_idx;
  logic                    send;

  assign rd_idx = 2'(word_bytes - 1) - tx_level[1:0]; // MSB goes first

  // Byte k of the response is picked by the current tx level
  always_comb begin
    byte_ok  = 1'b0;
    byte_sel = '0;
    case (resp_kind)
      resp_write: begin
        byte_ok = 1'b1;
        case (tx_level)
          3'd0:    byte_sel = resp_write_code;
          3'd1:    byte_sel = reg_addr;
          3'd2:    byte_sel = {7'b0, slv_err};
          default: byte_ok  = 1'b0;
        endcase
      end
      resp_read: begin
        byte_ok  = (tx_level < fifo_lvl_w'(word_bytes));
        byte_sel = rdata.bytes[rd_idx];
      end
      resp_error: begin
        byte_ok = 1'b1;
        case (tx_level)
          3'd0:    byte_sel = resp_error_code;
          3'd1:    byte_sel = {5'b0, fatal_status}; // Fatal bits above cmd error
          default: byte_ok  = 1'b0;
        endcase
      end
      default: byte_ok = 1'b0;
    endcase
  end

  // Skip a cycle after each write so the level can catch up
  assign send = resp_active && byte_ok && !tx_wr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      tx_wr <= 1'b0;
    else
      tx_wr <= send;
  end

  always_ff @(posedge clk) begin
    if (send) tx_wdata <= byte_sel;
  end

  a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
    tx_wr |=> !tx_wr);

endmodule

`default_nettype wire

//--- source/rx_field_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rx_field_capture (
  input  logic clk,
  input  logic rst_n,
  input  logic [bridge_proto_pkg::rx_depth-1:0][bridge_proto_pkg::uart_byte_w-1:0] rx_array,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0] rx_level,
  input  logic cap_cmd,
  input  logic cap_addr,
  input  logic cap_wdata,
  output logic cmd_valid,
  output logic cmd_is_read,
  output logic ready,
  output logic [reg_bus_pkg::apb_addr_w-1:0] reg_addr,
  output reg_bus_pkg::reg_word_u wdata
);
  import bridge_proto_pkg::*;
  import reg_bus_pkg::*;

  logic [3:0] cmd_nib;

  assign cmd_nib = rx_array[0][3:0];
  assign ready   = (rx_level < rx_ready_limit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid   <= 1'b0;
      cmd_is_read <= 1'b0;
    end else if (cap_cmd) begin
      cmd_valid   <= (cmd_nib == cmd_reg_read) || (cmd_nib == cmd_reg_write);
      cmd_is_read <= (cmd_nib == cmd_reg_read);
    end
  end

  always_ff @(posedge clk) begin
    if (cap_addr) reg_addr <= rx_array[0];
    if (cap_wdata) begin
      // Oldest byte lands in the top byte
      for (int i = 0; i < word_bytes; i++) begin
        wdata.bytes[word_bytes-1-i] <= rx_array[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/uart_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_reg_bridge (
  input  logic clk,
  input  logic rst_n,
  input  logic [bridge_proto_pkg::rx_depth-1:0][bridge_proto_pkg::uart_byte_w-1:0] rx_array,
  input  logic rx_done,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0] rx_level,
  input  logic [1:0] fatal_errors,
  output logic rx_fifo_flush,
  output logic ready,
  output logic tx_req,
  input  logic tx_grant,
  output logic tx_wr,
  output logic [bridge_proto_pkg::uart_byte_w-1:0] tx_wdata,
  input  logic [bridge_proto_pkg::fifo_lvl_w-1:0] tx_level,
  output logic psel,
  output logic penable,
  output logic pwrite,
  output logic [reg_bus_pkg::apb_addr_w-1:0] paddr,
  output logic [reg_bus_pkg::apb_data_w-1:0] pwdata,
  input  logic [reg_bus_pkg::apb_data_w-1:0] prdata,
  input  logic pslverr
);
  import bridge_proto_pkg::*;
  import reg_bus_pkg::*;

  logic                   cmd_valid, cmd_is_read;
  logic                   cap_cmd, cap_addr, cap_wdata;
  logic                   apb_start, apb_write, resp_active, slv_err;
  logic [2:0]             fatal_status;
  logic [apb_addr_w-1:0]  reg_addr;
  reg_word_u              wdata, rdata;
  resp_kind_t             resp_kind;

  cmd_ctrl u_ctrl (
    .clk, .rst_n, .rx_done, .fatal_errors, .rx_level,
    .cmd_valid, .cmd_is_read, .tx_grant, .tx_level, .tx_wr,
    .rx_fifo_flush, .cap_cmd, .cap_addr, .cap_wdata,
    .apb_start, .apb_write, .resp_active, .tx_req,
    .resp_kind, .fatal_status
  );

  rx_field_capture u_capture (
    .clk, .rst_n, .rx_array, .rx_level,
    .cap_cmd, .cap_addr, .cap_wdata,
    .cmd_valid, .cmd_is_read, .ready, .reg_addr, .wdata
  );

  apb_access u_apb (
    .clk, .rst_n, .apb_start, .apb_write, .reg_addr, .wdata,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pslverr, .rdata, .slv_err
  );

  resp_builder u_resp (
    .clk, .rst_n, .resp_active, .resp_kind, .tx_level,
    .reg_addr, .rdata, .slv_err, .fatal_status,
    .tx_wr, .tx_wdata
  );

endmodule

`default_nettype wire

//--- tb/tb_uart_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_reg_bridge;
  import bridge_proto_pkg::*;
  import reg_bus_pkg::*;

  localparam int num_txn    = 16;
  localparam int txn_cycles = 60;  // Longest transaction incl. back-pressure
  localparam int cycle_limit = num_txn * txn_cycles;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [rx_depth-1:0][uart_byte_w-1:0] rx_array = '0;
  logic rx_done = 1'b0;
  logic [fifo_lvl_w-1:0] rx_level = '0;
  logic [1:0] fatal_errors = 2'b00;
  logic tx_grant = 1'b0;
  logic [fifo_lvl_w-1:0] tx_level = '0;
  logic rx_fifo_flush, ready, tx_req, tx_wr, psel, penable, pwrite, pslverr;
  logic [uart_byte_w-1:0] tx_wdata;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata, prdata;

  logic [31:0] regs [256];
  logic [31:0] shadow [256];
  logic [7:0] rx_pending [$];
  logic [34:0] exp_q [$];   // {length, bytes right aligned}
  logic [34:0] got_q [$];
  string name_q [$];
  logic hold_grant = 1'b0;
  logic env_clear = 1'b0;
  logic [31:0] frame = '0;  // Tx bytes of the current response
  logic prev_req = 1'b0;
  int frames_done = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] lcg_state = 32'h80e2_abc1;

  uart_reg_bridge UUT (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'hA5, a + 8'h3C};
  endfunction

  // Expected response from the protocol rules
  function automatic logic [34:0] ref_response(input logic [7:0] cmd_byte,
      input logic [7:0] addr, input logic [1:0] fatal, input logic [31:0] word);
    if (cmd_byte[3:0] != 4'h1 && cmd_byte[3:0] != 4'h2)
      return {3'd2, 16'h0, 8'h0F, 8'h01};
    else if (fatal != 2'b00)
      return {3'd2, 16'h0, 8'h0F, 5'b0, fatal, 1'b0};
    else if (cmd_byte[3:0] == 4'h2)
      return {3'd3, 8'h0, 8'h05, addr, 7'b0, addr >= 8'hF0};
    else
      return {3'd4, word};
  endfunction

  task automatic check(input string name, input logic [34:0] exp, input logic [34:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // APB register file, collapsed access
  initial for (int i = 0; i < 256; i++) regs[i] = fill_word(8'(i));
  assign prdata  = regs[paddr];
  assign pslverr = psel && (paddr >= 8'hF0);
  always @(posedge clk) begin
    if (psel && penable && pwrite && paddr < 8'hF0) regs[paddr] <= pwdata;
  end

  // Rx FIFO, one byte per cycle from the pending queue
  always @(posedge clk) begin : rx_model
    logic flush_s;
    flush_s = rx_fifo_flush || env_clear;
    #1;
    rx_done = 1'b0;
    if (flush_s) begin
      rx_level = '0;
      rx_array = '0;
    end else if (rx_pending.size() > 0 && rx_level != 3'd7) begin
      rx_array[rx_level] = rx_pending.pop_front();
      rx_level = rx_level + 1'b1;
      rx_done = 1'b1;
    end
  end

  // Tx FIFO, frame is recorded when the request drops
  always @(posedge clk) begin : tx_model
    logic req_s, wr_s;
    logic [7:0] wd_s;
    req_s = tx_req;
    wr_s = tx_wr;
    wd_s = tx_wdata;
    #1;
    if (wr_s) begin
      frame = {frame[23:0], wd_s};
      tx_level = tx_level + 1'b1;
    end
    tx_grant = req_s && !hold_grant;
    if (prev_req && !req_s) begin
      got_q.push_back({tx_level, frame});
      frames_done++;
      tx_level = '0;
      frame = '0;
    end
    prev_req = req_s;
  end

  always @(posedge clk) begin : compare
    if (got_q.size() > 0 && exp_q.size() > 0)
      check(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the bridge stopped responding", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_flush();
    do @(posedge clk); while (rx_fifo_flush !== 1'b1);
    #1;
  endtask

  task automatic wait_frames(input int n);
    while (frames_done < n) next_edge();
  endtask

  task automatic run_txn(input string name, input logic [7:0] cmd_byte,
      input logic [7:0] addr, input logic [31:0] data, input logic [1:0] fatal);
    int target;
    target = frames_done + 1;
    name_q.push_back(name);
    exp_q.push_back(ref_response(cmd_byte, addr, fatal, shadow[addr]));
    if (cmd_byte[3:0] == 4'h2 && fatal == 2'b00 && addr < 8'hF0) shadow[addr] = data;
    rx_pending.push_back(cmd_byte);
    if (cmd_byte[3:0] == 4'h1 || cmd_byte[3:0] == 4'h2) begin
      wait_flush();
      if (fatal != 2'b00) begin
        fatal_errors = fatal;  // Seen in the address wait
        while (!tx_req) next_edge();
        fatal_errors = 2'b00;
      end else begin
        rx_pending.push_back(addr);
        if (cmd_byte[3:0] == 4'h2) begin
          wait_flush();
          for (int i = 3; i >= 0; i--) rx_pending.push_back(data[i*8 +: 8]);
        end
      end
    end
    wait_frames(target);
  endtask

  initial begin
    logic [7:0] addrs [4];
    logic [31:0] word;
    for (int i = 0; i < 256; i++) shadow[i] = fill_word(8'(i));
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_edge();
    check("reset_outputs", 35'b0,
          {29'b0, tx_req, tx_wr, psel, penable, pwrite, rx_fifo_flush});

    for (int i = 0; i < 4; i++) begin
      lcg_state = lcg_next(lcg_state);
      addrs[i] = lcg_state[15:8] % 8'hF0;
      word = lcg_next(lcg_state);
      lcg_state = word;
      run_txn("write", {lcg_state[27:24], 4'h2}, addrs[i], word, 2'b00);
    end
    for (int i = 0; i < 4; i++) run_txn("read_back", 8'h01, addrs[i], 32'h0, 2'b00);

    lcg_state = lcg_next(lcg_state);
    run_txn("write_slverr", 8'h32, 8'hF0 | lcg_state[3:0], lcg_state, 2'b00);
    run_txn("read_slverr_reg", 8'h01, 8'hF5, 32'h0, 2'b00);
    run_txn("unknown_cmd", 8'h07, 8'h00, 32'h0, 2'b00);
    run_txn("unknown_fec", 8'h43, 8'h00, 32'h0, 2'b00);
    run_txn("fatal_01", 8'h01, 8'h10, 32'h0, 2'b01);
    run_txn("fatal_10", 8'h02, 8'h20, 32'h0, 2'b10);

    // Grant withheld so rx bytes pile up unflushed
    hold_grant = 1'b1;
    name_q.push_back("ready_txn");
    exp_q.push_back(ref_response(8'h0C, 8'h00, 2'b00, 32'h0));
    rx_pending.push_back(8'h0C);
    while (!tx_req) next_edge();
    for (int i = 0; i < 6; i++) rx_pending.push_back(8'(i));
    while (rx_level != 3'd6) next_edge();
    next_edge();
    check("ready_at_6", 35'd1, {34'b0, ready});
    rx_pending.push_back(8'hAA);
    while (rx_level != 3'd7) next_edge();
    next_edge();
    check("ready_at_7", 35'd0, {34'b0, ready});
    env_clear = 1'b1;
    next_edge();
    env_clear = 1'b0;
    hold_grant = 1'b0;
    wait_frames(frames_done + 1);

    while (exp_q.size() > 0) next_edge();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
